// ==== i2c_master.f ====
rtl/i2c_cfg_pkg.sv
rtl/i2c_proto_pkg.sv
rtl/i2c_scl_gen.sv
rtl/i2c_byte_engine.sv
rtl/i2c_master_fsm.sv
rtl/i2c_master.sv
dv/i2c_slave_model.sv
dv/tb_i2c_master.sv

// ==== Bender.yml ====
package:
  name: i2c_master

sources:
  - files:
      - rtl/i2c_cfg_pkg.sv
      - rtl/i2c_proto_pkg.sv
      - rtl/i2c_scl_gen.sv
      - rtl/i2c_byte_engine.sv
      - rtl/i2c_master_fsm.sv
      - rtl/i2c_master.sv
  - target: test
    files:
      - dv/i2c_slave_model.sv
      - dv/tb_i2c_master.sv

// ==== dv/tb_i2c_master.sv ====
`timescale 1ns/1ps

// I2C master testbench
// runs a command table against the EEPROM-like target, write data from an LFSR

module tb_i2c_master
    import i2c_cfg_pkg::*;
    import i2c_proto_pkg::*;
();

    localparam int N_CMD = 9;

    logic        clk;
    logic        rst_n;
    logic        start;
    logic        rw;
    logic [6:0]  dev_addr;
    logic [7:0]  word_addr;
    logic [7:0]  len;
    logic [7:0]  wdata;
    logic        ready;
    logic        done;
    logic        error;
    logic        wvalid;
    logic        rvalid;
    logic [7:0]  rdata;
    logic        scl;
    logic        mst_sda;
    logic        mst_sda_oe;
    tri1         sda_bus;                  // pulled up wired-AND bus

    logic [24:0] cmd_tbl [N_CMD];          // {exp_err, rw, dev, word addr, len}
    logic [7:0]  shadow [256];
    logic [31:0] lfsr;
    int unsigned cycle_cnt = 0;
    int unsigned timeout_cycles = 0;

    assign sda_bus = (mst_sda_oe && !mst_sda) ? 1'b0 : 1'bz;

    i2c_master DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_i     (start),
        .rw_i        (rw),
        .dev_addr_i  (dev_addr),
        .word_addr_i (word_addr),
        .len_i       (len),
        .wdata_i     (wdata),
        .ready_o     (ready),
        .done_o      (done),
        .error_o     (error),
        .wvalid_o    (wvalid),
        .rvalid_o    (rvalid),
        .rdata_o     (rdata),
        .scl_o       (scl),
        .sda_i       (sda_bus),
        .sda_o       (mst_sda),
        .sda_oe_o    (mst_sda_oe)
    );

    i2c_slave_model #(.DEV_ADDR(7'h50)) u_slave (
        .scl_i  (scl),
        .sda_io (sda_bus)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ==================================================
    // helpers
    // ==================================================
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        if (got !== exp)
            abort_run($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    function automatic logic [24:0] cmd_entry(input logic exp_err, input logic rw_b,
                                              input logic [6:0] dev, input logic [7:0] wa,
                                              input logic [7:0] n);
        return {exp_err, rw_b, dev, wa, n};
    endfunction

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic rand_byte(output logic [7:0] b);
        for (int k = 0; k < 8; k++) begin
            b    = {b[6:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // idle gap after reset or a transfer with the bus parked and no status pulses
    task automatic wait_ready();
        int n;
        n = 0;
        while (ready !== 1'b1) begin
            @(negedge clk);
            n++;
            check_eq("status pulses", {done, error, wvalid, rvalid}, 4'h0);
            check_eq("scl_o/sda_oe_o", {scl, mst_sda_oe}, 2'b10);
            if (n > STARTUP_DELAY + 4)
                abort_run("ready_o did not come back after the idle delay");
        end
    endtask

    task automatic run_cmd(input logic [24:0] c);
        logic [7:0] wbytes [256];
        logic       exp_err;
        logic       rw_b;
        logic [7:0] wa;
        logic [7:0] n;
        int         i;
        int         widx;
        int         nw;
        int         nr;
        int         nd;
        int         ne;
        bit         fin;
        exp_err = c[24];
        rw_b    = c[23];
        wa      = c[15:8];
        n       = c[7:0];
        widx    = 0;
        nw      = 0;
        nr      = 0;
        nd      = 0;
        ne      = 0;
        fin     = 1'b0;
        wbytes[0] = 8'h00;
        if (rw_b == RW_WRITE) begin
            for (i = 0; i <= n; i++)
                rand_byte(wbytes[i]);
            if (!exp_err)
                for (i = 0; i <= n; i++)
                    shadow[8'(wa + i)] = wbytes[i];
        end

        @(posedge clk);
        #2;
        start     = 1'b1;
        rw        = rw_b;
        dev_addr  = c[22:16];
        word_addr = wa;
        len       = n;
        wdata     = wbytes[0];             // first byte held at start
        @(posedge clk);
        #2;
        start = 1'b0;
        wdata = ~wbytes[0];                // first byte now only in the sequencer's copy
        @(negedge clk);
        check_eq("ready_o after accept", ready, 1'b0);

        while (!fin) begin
            @(negedge clk);
            if (wvalid) begin
                nw++;
                widx++;
            end
            if (rvalid) begin
                check_eq("rdata_o", rdata, shadow[8'(wa + nr)]);
                nr++;
            end
            if (done) begin
                nd++;
                fin = 1'b1;
            end
            if (error) begin
                ne++;
                fin = 1'b1;
            end
            if (wvalid && widx <= n) begin
                @(posedge clk);
                #2;
                wdata = wbytes[widx];      // next byte within one scl period
            end
        end
        check_eq("ready_o at end", ready, 1'b0);
        check_eq("done_o pulses", nd, !exp_err);
        check_eq("error_o pulses", ne, exp_err);
        check_eq("wvalid_o pulses", nw, (rw_b == RW_WRITE && !exp_err) ? n + 1 : 0);
        check_eq("rvalid_o pulses", nr, (rw_b == RW_READ && !exp_err) ? n + 1 : 0);
    endtask

    // ==================================================
    // timeout
    // ==================================================
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (timeout_cycles != 0 && cycle_cnt > timeout_cycles)
            abort_run("timeout, the DUT stopped responding");
    end

    // ==================================================
    // main sequence
    // ==================================================
    initial begin
        int i;
        rst_n     = 1'b0;
        start     = 1'b0;
        rw        = RW_WRITE;
        dev_addr  = '0;
        word_addr = '0;
        len       = '0;
        wdata     = '0;
        lfsr      = 32'hc63a;

        cmd_tbl[0] = cmd_entry(1'b0, RW_WRITE, 7'h50, 8'h10, 8'd0);
        cmd_tbl[1] = cmd_entry(1'b0, RW_READ,  7'h50, 8'h10, 8'd0);
        cmd_tbl[2] = cmd_entry(1'b0, RW_WRITE, 7'h50, 8'h40, 8'd5);   // burst
        cmd_tbl[3] = cmd_entry(1'b0, RW_READ,  7'h50, 8'h40, 8'd5);
        cmd_tbl[4] = cmd_entry(1'b1, RW_WRITE, 7'h51, 8'h20, 8'd1);   // nobody home
        cmd_tbl[5] = cmd_entry(1'b0, RW_READ,  7'h50, 8'h41, 8'd2);
        cmd_tbl[6] = cmd_entry(1'b1, RW_READ,  7'h51, 8'h40, 8'd0);
        cmd_tbl[7] = cmd_entry(1'b0, RW_WRITE, 7'h50, 8'hff, 8'd0);
        cmd_tbl[8] = cmd_entry(1'b0, RW_READ,  7'h50, 8'hff, 8'd0);   // last address

        // nine scl periods per byte plus the idle gaps with a factor two margin
        timeout_cycles = (N_CMD + 1) * STARTUP_DELAY;
        for (i = 0; i < N_CMD; i++)
            timeout_cycles += (cmd_tbl[i][7:0] + 4) * 9 * SCL_DIV;
        timeout_cycles *= 2;

        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        check_eq("ready_o after reset", ready, 1'b0);
        check_eq("scl_o/sda_o/sda_oe_o after reset", {scl, mst_sda, mst_sda_oe}, 3'b110);
        wait_ready();

        for (i = 0; i < N_CMD; i++) begin
            run_cmd(cmd_tbl[i]);
            wait_ready();
        end

        $display("all tests passed");
        $finish;
    end

endmodule

// ==== dv/i2c_slave_model.sv ====
`timescale 1ns/1ps

// I2C target model
// EEPROM-like memory behind one device address, pointer increments per byte

module i2c_slave_model import i2c_proto_pkg::*; #(
    parameter logic [6:0] DEV_ADDR = 7'h50
) (
    input  logic scl_i,
    inout  wire  sda_io
);

    typedef enum logic [2:0] {S_IDLE, S_ADDR, S_WADDR, S_WRITE, S_READ} slv_state_e;

    logic [7:0] mem [256];
    slv_state_e state     = S_IDLE;
    logic [7:0] sr        = '0;         // receive shift register
    logic [7:0] rd_byte   = '0;
    logic [7:0] ptr       = '0;
    int         bit_cnt   = 0;
    logic       ack_phase = 1'b0;
    logic       host_nack = 1'b0;
    logic       sda_low   = 1'b0;
    logic       scl_q     = 1'b1;
    logic       sda_q     = 1'b1;

    assign sda_io = sda_low ? 1'b0 : 1'bz;     // open drain

    // rising scl, data is stable here
    task automatic sample_bit();
        if (ack_phase) begin
            host_nack = (sda_io !== 1'b0);
        end else if (state != S_IDLE) begin
            if (state != S_READ)
                sr = {sr[6:0], sda_io};
            bit_cnt = bit_cnt + 1;
        end
    endtask

    // byte complete, decide on the ack slot
    task automatic end_of_byte();
        ack_phase = 1'b1;
        sda_low   = 1'b1;
        case (state)
            S_ADDR: begin
                if (sr[7:1] != DEV_ADDR) begin
                    state     = S_IDLE;   // not ours, stay off the bus
                    ack_phase = 1'b0;
                    sda_low   = 1'b0;
                end else if (sr[0] == RW_READ) begin
                    state     = S_READ;
                    host_nack = 1'b0;
                end else begin
                    state = S_WADDR;
                end
            end
            S_WADDR: begin
                ptr   = sr;
                state = S_WRITE;
            end
            S_WRITE: begin
                mem[ptr] = sr;
                ptr      = ptr + 1'b1;
            end
            default: sda_low = 1'b0;      // host answers on reads
        endcase
    endtask

    // falling scl, change sda while scl is low
    task automatic drive_bit();
        if (state == S_IDLE) begin
            sda_low = 1'b0;
        end else if (ack_phase) begin
            ack_phase = 1'b0;
            bit_cnt   = 0;
            sda_low   = 1'b0;
            if (state == S_READ) begin
                if (host_nack) begin
                    state = S_IDLE;       // last byte was nacked
                end else begin
                    rd_byte = mem[ptr];
                    ptr     = ptr + 1'b1;
                    sda_low = !rd_byte[7];
                end
            end
        end else if (bit_cnt == BITS_PER_BYTE) begin
            end_of_byte();
        end else if (state == S_READ) begin
            sda_low = !rd_byte[7 - bit_cnt];
        end
    endtask

    // ==================================================
    // bus event decode
    // ==================================================
    always @(scl_i or sda_io) begin
        if (scl_q === 1'b1 && scl_i === 1'b1 && sda_q !== sda_io) begin
            if (sda_io === 1'b0) begin
                state     = S_ADDR;       // start or repeated start
                bit_cnt   = 0;
                ack_phase = 1'b0;
                sda_low   = 1'b0;
            end else if (sda_io === 1'b1) begin
                state   = S_IDLE;         // stop
                sda_low = 1'b0;
            end
        end else if (scl_q === 1'b0 && scl_i === 1'b1) begin
            sample_bit();
        end else if (scl_q === 1'b1 && scl_i === 1'b0) begin
            drive_bit();
        end
        scl_q = scl_i;
        sda_q = sda_io;
    end

endmodule

// ==== rtl/i2c_master.sv ====
`timescale 1ns/1ps

// I2C master top level
// clock generator, byte engine and sequencer behind a start/ready host port

module i2c_master import i2c_proto_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    // host side
    input  logic       start_i,
    input  logic       rw_i,
    input  logic [6:0] dev_addr_i,
    input  logic [7:0] word_addr_i,
    input  logic [7:0] len_i,
    input  logic [7:0] wdata_i,
    output logic       ready_o,
    output logic       done_o,
    output logic       error_o,
    output logic       wvalid_o,
    output logic       rvalid_o,
    output logic [7:0] rdata_o,
    // bus side
    output logic       scl_o,
    input  logic       sda_i,
    output logic       sda_o,
    output logic       sda_oe_o
);

    logic       scl_run;
    logic       scl_high_stb;
    logic       scl_low_stb;
    byte_op_e   byte_op;
    logic [7:0] byte_tx;
    logic       cond_start;
    logic       cond_stop;
    logic       cond_rstart;
    logic       byte_done;
    logic       ack_ok;
    logic [7:0] rx_byte;

    i2c_scl_gen u_scl_gen (
        .clk            (clk),
        .rst_n          (rst_n),
        .run_i          (scl_run),
        .scl_o          (scl_o),
        .scl_high_stb_o (scl_high_stb),
        .scl_low_stb_o  (scl_low_stb)
    );

    i2c_byte_engine u_byte_engine (
        .clk            (clk),
        .rst_n          (rst_n),
        .scl_high_stb_i (scl_high_stb),
        .scl_low_stb_i  (scl_low_stb),
        .op_i           (byte_op),
        .tx_byte_i      (byte_tx),
        .cond_start_i   (cond_start),
        .cond_stop_i    (cond_stop),
        .cond_rstart_i  (cond_rstart),
        .sda_i          (sda_i),
        .sda_o          (sda_o),
        .sda_oe_o       (sda_oe_o),
        .byte_done_o    (byte_done),
        .ack_ok_o       (ack_ok),
        .rx_byte_o      (rx_byte)
    );

    i2c_master_fsm u_fsm (
        .clk            (clk),
        .rst_n          (rst_n),
        .start_i        (start_i),
        .rw_i           (rw_i),
        .dev_addr_i     (dev_addr_i),
        .word_addr_i    (word_addr_i),
        .len_i          (len_i),
        .wdata_i        (wdata_i),
        .byte_done_i    (byte_done),
        .ack_ok_i       (ack_ok),
        .rx_byte_i      (rx_byte),
        .scl_high_stb_i (scl_high_stb),
        .run_o          (scl_run),
        .op_o           (byte_op),
        .tx_byte_o      (byte_tx),
        .cond_start_o   (cond_start),
        .cond_stop_o    (cond_stop),
        .cond_rstart_o  (cond_rstart),
        .ready_o        (ready_o),
        .done_o         (done_o),
        .error_o        (error_o),
        .wvalid_o       (wvalid_o),
        .rvalid_o       (rvalid_o),
        .rdata_o        (rdata_o)
    );

endmodule

// ==== rtl/i2c_master_fsm.sv ====
`timescale 1ns/1ps

// I2C transaction sequencer
// takes host commands, steps through the bus phases and reports status

module i2c_master_fsm
    import i2c_cfg_pkg::*;
    import i2c_proto_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start_i,
    input  logic       rw_i,
    input  logic [6:0] dev_addr_i,
    input  logic [7:0] word_addr_i,
    input  logic [7:0] len_i,
    input  logic [7:0] wdata_i,
    input  logic       byte_done_i,
    input  logic       ack_ok_i,
    input  logic [7:0] rx_byte_i,
    input  logic       scl_high_stb_i,
    output logic       run_o,
    output byte_op_e   op_o,
    output logic [7:0] tx_byte_o,
    output logic       cond_start_o,
    output logic       cond_stop_o,
    output logic       cond_rstart_o,
    output logic       ready_o,
    output logic       done_o,
    output logic       error_o,
    output logic       wvalid_o,
    output logic       rvalid_o,
    output logic [7:0] rdata_o
);

    i2c_state_e state_q, state_d;

    logic [$clog2(STARTUP_DELAY)-1:0] dly_cnt;
    logic       dly_done;
    logic       accept;
    logic       rw_q;
    logic       first_q;        // first data byte still comes from wdata_q
    logic [6:0] dev_q;
    logic [7:0] waddr_q;
    logic [7:0] wdata_q;
    logic [7:0] rem_q;          // data bytes left after the current one
    logic       last_byte;
    logic       send_state;

    assign dly_done   = (int'(dly_cnt) == STARTUP_DELAY - 1);
    assign ready_o    = (state_q == READY);
    assign accept     = ready_o && start_i;
    assign last_byte  = (rem_q == '0);
    assign send_state = state_q inside {DEV_ADDR_W, DEV_ADDR_R, WORD_ADDR, WR_DATA};

    // ==================================================
    // next state
    // ==================================================
    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE:       if (dly_done) state_d = READY;
            READY:      if (start_i) state_d = START;
            START:      if (scl_high_stb_i) state_d = DEV_ADDR_W;
            RSTART:     if (scl_high_stb_i) state_d = DEV_ADDR_R;
            DEV_ADDR_W: if (byte_done_i) state_d = ack_ok_i ? WORD_ADDR : IDLE;
            DEV_ADDR_R: if (byte_done_i) state_d = ack_ok_i ? RD_DATA : IDLE;
            WORD_ADDR: begin
                if (byte_done_i) begin
                    if (!ack_ok_i)
                        state_d = IDLE;
                    else
                        state_d = (rw_q == RW_WRITE) ? WR_DATA : RSTART;
                end
            end
            WR_DATA: begin
                if (byte_done_i) begin
                    if (!ack_ok_i)
                        state_d = IDLE;     // abort, no stop
                    else if (last_byte)
                        state_d = STOP;
                end
            end
            RD_DATA:    if (byte_done_i && last_byte) state_d = STOP;
            STOP:       if (scl_high_stb_i) state_d = IDLE;
            default:    state_d = IDLE;
        endcase
    end

    // ==================================================
    // engine requests
    // ==================================================
    always_comb begin
        run_o         = !(state_q inside {IDLE, READY});
        cond_start_o  = (state_q == START);
        cond_rstart_o = (state_q == RSTART);
        cond_stop_o   = (state_q == STOP);
        op_o          = OP_NONE;
        tx_byte_o     = '0;
        case (state_q)
            DEV_ADDR_W: begin
                op_o      = OP_SEND;
                tx_byte_o = {dev_q, RW_WRITE};
            end
            DEV_ADDR_R: begin
                op_o      = OP_SEND;
                tx_byte_o = {dev_q, RW_READ};
            end
            WORD_ADDR: begin
                op_o      = OP_SEND;
                tx_byte_o = waddr_q;
            end
            WR_DATA: begin
                op_o      = OP_SEND;
                tx_byte_o = first_q ? wdata_q : wdata_i;
            end
            RD_DATA:  op_o = last_byte ? OP_RECV_NACK : OP_RECV_ACK;
            default: ;
        endcase
    end

    // ==================================================
    // control registers and status
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= IDLE;
            dly_cnt  <= '0;
            rw_q     <= RW_WRITE;
            first_q  <= 1'b0;
            rem_q    <= '0;
            done_o   <= 1'b0;
            error_o  <= 1'b0;
            wvalid_o <= 1'b0;
            rvalid_o <= 1'b0;
        end else begin
            state_q <= state_d;
            dly_cnt <= (state_q == IDLE) ? dly_cnt + 1'b1 : '0;
            if (accept) begin
                rw_q    <= rw_i;
                rem_q   <= len_i;
                first_q <= 1'b1;
            end
            if (byte_done_i && !last_byte &&
                ((state_q == WR_DATA && ack_ok_i) || state_q == RD_DATA))
                rem_q <= rem_q - 1'b1;
            if (byte_done_i && state_q == WR_DATA)
                first_q <= 1'b0;
            done_o   <= (state_q == STOP) && scl_high_stb_i;
            error_o  <= byte_done_i && !ack_ok_i && send_state;
            wvalid_o <= byte_done_i && ack_ok_i && (state_q == WR_DATA);
            rvalid_o <= byte_done_i && (state_q == RD_DATA);
        end
    end

    // command payload and read data
    always_ff @(posedge clk) begin
        if (accept) begin
            dev_q   <= dev_addr_i;
            waddr_q <= word_addr_i;
            wdata_q <= wdata_i;
        end
        if (byte_done_i && state_q == RD_DATA)
            rdata_o <= rx_byte_i;
    end

    a_done_err_excl: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(done_o && error_o)
    ) else $error("done and error asserted together");

endmodule

// ==== rtl/i2c_byte_engine.sv ====
`timescale 1ns/1ps

// I2C byte engine
// shifts one byte plus acknowledge on SDA and shapes START, repeated START and STOP

module i2c_byte_engine import i2c_proto_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       scl_high_stb_i,
    input  logic       scl_low_stb_i,
    input  byte_op_e   op_i,
    input  logic [7:0] tx_byte_i,
    input  logic       cond_start_i,
    input  logic       cond_stop_i,
    input  logic       cond_rstart_i,
    input  logic       sda_i,
    output logic       sda_o,
    output logic       sda_oe_o,
    output logic       byte_done_o,
    output logic       ack_ok_o,
    output logic [7:0] rx_byte_o
);

    logic       busy;
    byte_op_e   op_q;
    logic [3:0] bit_cnt;        // 0..7 data slots, 8 is the ack slot
    logic [7:0] tx_sr;
    logic       ack_slot;

    assign ack_slot    = (bit_cnt == 4'(BITS_PER_BYTE));
    assign byte_done_o = busy && scl_high_stb_i && ack_slot;
    assign ack_ok_o    = ~sda_i;   // target pulls low to ack

    // ==================================================
    // slot control and sda drive
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            op_q     <= OP_NONE;
            bit_cnt  <= '0;
            sda_o    <= 1'b1;
            sda_oe_o <= 1'b0;
        end else if (!busy) begin
            if (op_i != OP_NONE) begin
                busy    <= 1'b1;
                op_q    <= op_i;
                bit_cnt <= '0;
            end
            // bus conditions, sda moves while scl high only here
            if (scl_high_stb_i && (cond_start_i || cond_rstart_i)) begin
                sda_o    <= 1'b0;
                sda_oe_o <= 1'b1;
            end else if (scl_high_stb_i && cond_stop_i) begin
                sda_o    <= 1'b1;
                sda_oe_o <= 1'b0;      // release, pull-up finishes the stop
            end else if (scl_low_stb_i && cond_rstart_i) begin
                sda_o    <= 1'b1;      // raise sda before the repeated start
                sda_oe_o <= 1'b1;
            end else if (scl_low_stb_i && cond_stop_i) begin
                sda_o    <= 1'b0;
                sda_oe_o <= 1'b1;
            end
        end else begin
            if (scl_low_stb_i) begin
                if (ack_slot) begin
                    if (op_q == OP_SEND) begin
                        sda_oe_o <= 1'b0;  // let the target answer
                    end else begin
                        sda_o    <= (op_q == OP_RECV_NACK);
                        sda_oe_o <= 1'b1;
                    end
                end else if (op_q == OP_SEND) begin
                    sda_o    <= (bit_cnt == '0) ? tx_byte_i[7] : tx_sr[7];
                    sda_oe_o <= 1'b1;
                end else begin
                    sda_oe_o <= 1'b0;
                end
            end
            if (scl_high_stb_i) begin
                if (ack_slot) begin
                    busy    <= 1'b0;
                    bit_cnt <= '0;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    // ==================================================
    // shift registers
    // ==================================================
    always_ff @(posedge clk) begin
        // tx byte taken at the first low strobe, msb first
        if (busy && scl_low_stb_i && op_q == OP_SEND && !ack_slot) begin
            if (bit_cnt == '0)
                tx_sr <= {tx_byte_i[6:0], 1'b0};
            else
                tx_sr <= {tx_sr[6:0], 1'b0};
        end
        if (busy && scl_high_stb_i && op_q != OP_SEND && !ack_slot)
            rx_byte_o <= {rx_byte_o[6:0], sda_i};
    end

    // ==================================================
    // checks
    // ==================================================
    // data bits move in the low phase, conditions only on a high strobe
    a_sda_timing: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$stable(sda_o) |-> $past(scl_low_stb_i) ||
            $past(scl_high_stb_i && (cond_start_i || cond_rstart_i || cond_stop_i))
    ) else $error("sda changed outside the scl low phase");

endmodule

// ==== rtl/i2c_scl_gen.sv ====
`timescale 1ns/1ps

// SCL clock generator
// divides the system clock and marks the middle of each SCL half period

module i2c_scl_gen import i2c_cfg_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic run_i,
    output logic scl_o,
    output logic scl_high_stb_o,
    output logic scl_low_stb_o
);

    logic [SCL_CNT_W-1:0] cnt;

    // ==================================================
    // divider and scl
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt            <= '0;
            scl_o          <= 1'b1;
            scl_high_stb_o <= 1'b0;
            scl_low_stb_o  <= 1'b0;
        end else if (!run_i) begin
            cnt            <= '0;      // park with scl high
            scl_o          <= 1'b1;
            scl_high_stb_o <= 1'b0;
            scl_low_stb_o  <= 1'b0;
        end else begin
            if (int'(cnt) == SCL_DIV - 1)
                cnt <= '0;
            else
                cnt <= cnt + 1'b1;

            if (int'(cnt) == SCL_DIV / 2 - 1)
                scl_o <= 1'b0;         // falling edge at half period
            else if (int'(cnt) == SCL_DIV - 1)
                scl_o <= 1'b1;

            // quarter period after each edge
            scl_high_stb_o <= (int'(cnt) == SCL_DIV / 4 - 1);
            scl_low_stb_o  <= (int'(cnt) == SCL_DIV / 2 + SCL_DIV / 4 - 1);
        end
    end

    // ==================================================
    // checks
    // ==================================================
    a_stb_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(scl_high_stb_o && scl_low_stb_o)
    ) else $error("scl strobes overlap");

endmodule

// ==== rtl/i2c_proto_pkg.sv ====
// I2C protocol definitions
// sequencer states, byte engine opcodes and bit-level constants

package i2c_proto_pkg;

    // transaction phases of the sequencer
    typedef enum logic [3:0] {
        IDLE,
        READY,
        START,
        RSTART,         // repeated start before the read address
        DEV_ADDR_W,
        DEV_ADDR_R,
        WORD_ADDR,
        WR_DATA,
        RD_DATA,
        STOP
    } i2c_state_e;

    // byte engine commands
    typedef enum logic [1:0] {
        OP_NONE,
        OP_SEND,        // shift out, sample target ack
        OP_RECV_ACK,    // shift in, master acks
        OP_RECV_NACK    // shift in, master nacks the last byte
    } byte_op_e;

    localparam int   BITS_PER_BYTE = 8;
    localparam logic RW_WRITE      = 1'b0;
    localparam logic RW_READ       = 1'b1;

endpackage

// ==== rtl/i2c_cfg_pkg.sv ====
// I2C controller configuration
// system clock, bus clock and the derived divider and delay values

package i2c_cfg_pkg;

    // ==================================================
    // clocks
    // ==================================================
    localparam int SYS_CLK_HZ = 50_000_000;     // system clock
    localparam int SCL_HZ     = 400_000;        // fast mode bus clock

    // ==================================================
    // derived timing
    // ==================================================
    // system cycles per scl period
    localparam int SCL_DIV   = SYS_CLK_HZ / SCL_HZ;
    localparam int SCL_CNT_W = $clog2(SCL_DIV);

    // idle gap before ready, also between transfers
    localparam int STARTUP_DELAY = 2 * SCL_DIV;

endpackage
